/* hw/fu_pkg.sv */
package fu_pkg;

    // Units per category
    localparam int NUM_ALU  = 8;
    localparam int NUM_LS   = 4;
    localparam int NUM_MULT = 4;
    localparam int NUM_BEQ  = 4;

    localparam int FU_SIZE = NUM_ALU + NUM_LS + NUM_MULT + NUM_BEQ;

    // Exclusive upper slot index of each category
    localparam int ALU_OFFSET  = NUM_ALU;
    localparam int LS_OFFSET   = ALU_OFFSET + NUM_LS;
    localparam int MULT_OFFSET = LS_OFFSET + NUM_MULT;
    localparam int BEQ_OFFSET  = MULT_OFFSET + NUM_BEQ;

    localparam int FU_CAT = 4;
    localparam int XLEN   = 32;

    // Unit tag equals the slot index
    typedef logic [$clog2(FU_SIZE)-1:0] fu_num_t;

    // One-hot category, bit 0 ALU up to bit 3 branch
    typedef logic [FU_CAT-1:0] fu_cat_t;

    typedef logic [FU_SIZE-1:0] fu_vec_t;

    // Target holds the half-word address, byte address >> 1
    typedef struct packed {
        logic            taken;
        logic [XLEN-2:0] target;
    } branch_res_t;

    typedef union packed {
        logic [XLEN-1:0] word;
        branch_res_t     branch;
    } fu_result_u;

endpackage

/* hw/wb_if.sv */
interface wb_if import fu_pkg::*; ();

    fu_vec_t    valid;
    fu_vec_t    grant;
    fu_num_t    tag;
    fu_result_u gnt_data;

    modport bank (
        input  grant,
        output valid,
        output gnt_data
    );

    modport sel (
        input  valid,
        output grant,
        output tag
    );

    modport drv (
        input  grant,
        input  tag,
        input  gnt_data
    );

endinterface

/* hw/rot_priority_sel.sv */
module rot_priority_sel #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         req,
    input  logic [$clog2(WIDTH)-1:0] start,
    input  logic                     en,
    output logic [WIDTH-1:0]         gnt
);

    // Search upward from start, wrapping past the top bit
    always_comb begin
        logic found;
        int   idx;

        gnt   = '0;
        found = 1'b0;
        idx   = 0;
        for (int i = 0; i < WIDTH; i++) begin
            idx = (int'(start) + i) % WIDTH;
            if (en && !found && req[idx]) begin
                gnt[idx] = 1'b1;
                found    = 1'b1;
            end
        end
    end

endmodule

/* hw/fu_result_bank.sv */
module fu_result_bank import fu_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       complete,
    input  fu_num_t    complete_fu,
    input  fu_result_u complete_data,
    output fu_vec_t    slot_full,
    wb_if.bank         wb
);

    fu_result_u slot_data [FU_SIZE];
    fu_vec_t    slot_valid;
    logic       capture;

    // Only an empty slot takes a completion
    assign capture = complete && (int'(complete_fu) < FU_SIZE) && !slot_valid[complete_fu];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= '0;
        end else begin
            slot_valid <= slot_valid & ~wb.grant;
            if (capture) begin
                slot_valid[complete_fu] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            slot_data[complete_fu] <= complete_data;
        end
    end

    assign slot_full = slot_valid;
    assign wb.valid  = slot_valid;

    // AND-OR mux on the one-hot grant
    always_comb begin
        wb.gnt_data = '0;
        for (int i = 0; i < FU_SIZE; i++) begin
            if (wb.grant[i]) begin
                wb.gnt_data = wb.gnt_data | slot_data[i];
            end
        end
    end

endmodule

/* hw/fu_selector.sv */
module fu_selector import fu_pkg::*; (
    input  logic clock,
    input  logic rst_n,
    wb_if.sel    wb
);

    fu_cat_t    cat_req;
    fu_cat_t    cat_gnt;
    fu_vec_t    selection;
    logic [2:0] rot_cnt;

    assign cat_req[0] = |wb.valid[ALU_OFFSET-1:0];
    assign cat_req[1] = |wb.valid[LS_OFFSET-1:ALU_OFFSET];
    assign cat_req[2] = |wb.valid[MULT_OFFSET-1:LS_OFFSET];
    assign cat_req[3] = |wb.valid[BEQ_OFFSET-1:MULT_OFFSET];

    // Fixed priority, branch > mult > load/store > alu
    always_comb begin
        cat_gnt = '0;
        if (cat_req[3]) begin
            cat_gnt[3] = 1'b1;
        end else if (cat_req[2]) begin
            cat_gnt[2] = 1'b1;
        end else if (cat_req[1]) begin
            cat_gnt[1] = 1'b1;
        end else if (cat_req[0]) begin
            cat_gnt[0] = 1'b1;
        end
    end

    // Free-running rotation start
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rot_cnt <= '0;
        end else begin
            rot_cnt <= rot_cnt + 3'd1;
        end
    end

    rot_priority_sel #(.WIDTH(NUM_ALU)) alu_sel_i (
        .req   (wb.valid[ALU_OFFSET-1:0]),
        .start (rot_cnt),
        .en    (cat_gnt[0]),
        .gnt   (selection[ALU_OFFSET-1:0])
    );

    rot_priority_sel #(.WIDTH(NUM_LS)) ls_sel_i (
        .req   (wb.valid[LS_OFFSET-1:ALU_OFFSET]),
        .start (rot_cnt[1:0]),
        .en    (cat_gnt[1]),
        .gnt   (selection[LS_OFFSET-1:ALU_OFFSET])
    );

    rot_priority_sel #(.WIDTH(NUM_MULT)) mult_sel_i (
        .req   (wb.valid[MULT_OFFSET-1:LS_OFFSET]),
        .start (rot_cnt[1:0]),
        .en    (cat_gnt[2]),
        .gnt   (selection[MULT_OFFSET-1:LS_OFFSET])
    );

    rot_priority_sel #(.WIDTH(NUM_BEQ)) beq_sel_i (
        .req   (wb.valid[BEQ_OFFSET-1:MULT_OFFSET]),
        .start (rot_cnt[1:0]),
        .en    (cat_gnt[3]),
        .gnt   (selection[BEQ_OFFSET-1:MULT_OFFSET])
    );

    assign wb.grant = selection;

    // One-hot to slot index, zero when idle
    always_comb begin
        wb.tag = '0;
        for (int i = 0; i < FU_SIZE; i++) begin
            if (selection[i]) begin
                wb.tag = fu_num_t'(i);
            end
        end
    end

endmodule

/* hw/cdb_driver.sv */
module cdb_driver import fu_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    wb_if.drv               wb,
    output logic            cdb_valid,
    output fu_num_t         cdb_tag,
    output logic [XLEN-1:0] cdb_data,
    output logic            cdb_branch_taken,
    output logic [XLEN-1:0] cdb_branch_target
);

    logic is_branch;

    // Branch units sit in the top slots
    assign is_branch = (int'(wb.tag) >= MULT_OFFSET) && (int'(wb.tag) < BEQ_OFFSET)
                       && (|wb.grant);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cdb_valid        <= 1'b0;
            cdb_branch_taken <= 1'b0;
        end else begin
            cdb_valid        <= |wb.grant;
            cdb_branch_taken <= is_branch && wb.gnt_data.branch.taken;
        end
    end

    // Tag, data and branch target of the granted slot
    always_ff @(posedge clock) begin
        cdb_tag  <= wb.tag;
        cdb_data <= wb.gnt_data.word;
        if (is_branch) begin
            cdb_branch_target <= {wb.gnt_data.branch.target, 1'b0};
        end else begin
            cdb_branch_target <= '0;
        end
    end

endmodule

/* hw/fu_writeback_top.sv */
module fu_writeback_top import fu_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,

    input  logic            complete,
    input  fu_num_t         complete_fu,
    input  fu_result_u      complete_data,
    output fu_vec_t         slot_full,

    output logic            cdb_valid,
    output fu_num_t         cdb_tag,
    output logic [XLEN-1:0] cdb_data,
    output logic            cdb_branch_taken,
    output logic [XLEN-1:0] cdb_branch_target
);

    wb_if wb ();

    fu_result_bank bank_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .complete      (complete),
        .complete_fu   (complete_fu),
        .complete_data (complete_data),
        .slot_full     (slot_full),
        .wb            (wb.bank)
    );

    fu_selector selector_i (
        .clock (clock),
        .rst_n (rst_n),
        .wb    (wb.sel)
    );

    cdb_driver driver_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .wb                (wb.drv),
        .cdb_valid         (cdb_valid),
        .cdb_tag           (cdb_tag),
        .cdb_data          (cdb_data),
        .cdb_branch_taken  (cdb_branch_taken),
        .cdb_branch_target (cdb_branch_target)
    );

endmodule

/* bench/tb_fu_writeback.sv */
module tb_fu_writeback import fu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 100;
    localparam logic [XLEN-1:0] BR_TARGET = 32'h0000_4a6e;

    typedef struct packed {
        fu_num_t    fu;
        fu_result_u data;
        logic       burst;
    } stim_row_t;

    logic            clock;
    logic            rst_n;
    logic            complete;
    fu_num_t         complete_fu;
    fu_result_u      complete_data;
    fu_vec_t         slot_full;
    logic            cdb_valid;
    fu_num_t         cdb_tag;
    logic [XLEN-1:0] cdb_data;
    logic            cdb_branch_taken;
    logic [XLEN-1:0] cdb_branch_target;

    stim_row_t  stim_q [$];
    fu_vec_t    exp_valid;
    fu_result_u exp_data [FU_SIZE];
    int         group_cats [$];
    int         group_issued;

    fu_writeback_top fu_writeback_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_tag(input fu_num_t got, input fu_num_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_data(input fu_result_u got, input fu_result_u exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // 0 ALU, 1 load/store, 2 multiply, 3 branch
    function automatic int category_of(input fu_num_t fu);
        if (int'(fu) < ALU_OFFSET) return 0;
        if (int'(fu) < LS_OFFSET) return 1;
        if (int'(fu) < MULT_OFFSET) return 2;
        return 3;
    endfunction

    task automatic score_beat();
        fu_num_t t;
        t = cdb_tag;
        if (!exp_valid[t]) begin
            abort_run($sformatf("Fail at %0t: CDB beat for unit %0d with no completion pending",
                                $time, t));
        end
        check_data(fu_result_u'(cdb_data), exp_data[t], "cdb_data");
        if (category_of(t) == 3) begin
            check_flag(cdb_branch_taken, exp_data[t].word[XLEN-1], "cdb_branch_taken");
            check_data(fu_result_u'(cdb_branch_target), fu_result_u'(exp_data[t].word << 1),
                       "cdb_branch_target");
        end else begin
            check_flag(cdb_branch_taken, 1'b0, "cdb_branch_taken on non-branch");
        end
        exp_valid[t] = 1'b0;
        group_cats.push_back(category_of(t));
    endtask

    // Step to the falling edge and score any CDB beat
    task automatic next_cycle();
        @(negedge clock);
        if (cdb_valid) begin
            score_beat();
        end
    endtask

    task automatic issue_completion(input fu_num_t fu, input fu_result_u data);
        int n;
        for (n = 0; n < TIMEOUT && slot_full[fu]; n++) begin
            next_cycle();
        end
        if (slot_full[fu]) begin
            abort_run($sformatf("Timed out waiting for slot %0d to empty", fu));
        end
        complete      = 1'b1;
        complete_fu   = fu;
        complete_data = data;
        exp_valid[fu] = 1'b1;
        exp_data[fu]  = data;
        group_issued++;
        next_cycle();
        complete = 1'b0;
    endtask

    // Wait for every issued result to leave and check beat count and order
    task automatic drain_group();
        int n;
        for (n = 0; n < TIMEOUT && (exp_valid != '0 || slot_full != '0); n++) begin
            next_cycle();
        end
        if (exp_valid != '0 || slot_full != '0) begin
            abort_run("Timed out waiting for the result bank to drain");
        end
        if (group_cats.size() != group_issued) begin
            abort_run($sformatf("Fail at %0t: %0d CDB beats for %0d completions",
                                $time, group_cats.size(), group_issued));
        end
        for (int k = 1; k < group_cats.size(); k++) begin
            if (group_cats[k] > group_cats[k-1]) begin
                abort_run($sformatf("Fail at %0t: category %0d left after category %0d",
                                    $time, group_cats[k], group_cats[k-1]));
            end
        end
        group_cats.delete();
        group_issued = 0;
    endtask

    task automatic add_row(input int fu, input logic [XLEN-1:0] word, input logic burst);
        stim_row_t row;
        row.fu         = fu_num_t'(fu);
        row.data.word  = word;
        row.burst      = burst;
        stim_q.push_back(row);
    endtask

    initial begin
        stim_row_t row;
        logic      lone;

        rst_n         = 1'b0;
        complete      = 1'b0;
        complete_fu   = '0;
        complete_data = '0;
        exp_valid     = '0;
        group_issued  = 0;
        void'($urandom(32'h957b9366));

        // Lone completions
        add_row(5, $urandom, 1'b0);
        add_row(18, $urandom, 1'b0);
        // One unit per category in priority order
        add_row(16, $urandom, 1'b0);
        add_row(12, $urandom, 1'b1);
        add_row(8, $urandom, 1'b1);
        add_row(0, $urandom, 1'b1);
        // All eight ALUs back to back
        for (int u = 0; u < NUM_ALU; u++) begin
            add_row(u, $urandom, u != 0);
        end
        // Branch decode
        add_row(17, {1'b1, BR_TARGET[XLEN-1:1]}, 1'b0);
        add_row(3, $urandom | 32'h8000_0000, 1'b0);
        add_row(19, {1'b0, BR_TARGET[XLEN-1:1]}, 1'b0);

        repeat (8) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        for (int c = 0; c < 20; c++) begin
            next_cycle();
            check_flag(cdb_valid, 1'b0, "cdb_valid after reset");
            check_flag(cdb_branch_taken, 1'b0, "cdb_branch_taken after reset");
            check_flag(|slot_full, 1'b0, "slot_full after reset");
        end

        for (int i = 0; i < stim_q.size(); i++) begin
            row = stim_q[i];
            if (!row.burst) begin
                drain_group();
            end
            lone = !row.burst && (i + 1 == stim_q.size() || !stim_q[i+1].burst);
            issue_completion(row.fu, row.data);
            if (lone) begin
                check_flag(slot_full[row.fu], 1'b1, "slot_full one edge after completion");
                check_flag(cdb_valid, 1'b0, "cdb_valid one edge after completion");
                next_cycle();
                check_flag(cdb_valid, 1'b1, "cdb_valid two edges after completion");
                check_tag(cdb_tag, row.fu, "cdb_tag");
                check_flag(slot_full[row.fu], 1'b0, "slot_full after grant");
            end
        end
        drain_group();

        $display("test passed");
        $finish;
    end

endmodule

/* sim.f */
hw/fu_pkg.sv
hw/wb_if.sv
hw/rot_priority_sel.sv
hw/fu_result_bank.sv
hw/fu_selector.sv
hw/cdb_driver.sv
hw/fu_writeback_top.sv
bench/tb_fu_writeback.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= sim.f
TB_TOP     ?= tb_fu_writeback
RTL_TOP    ?= fu_writeback_top
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= test passed

RTL_SRCS := $(shell grep '^hw/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulation output
run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
